// ==== project.f ====
+incdir+include
hdl/rf_pkg.sv
hdl/issue_decode.sv
hdl/reg_bank.sv
hdl/operand_select.sv
hdl/rf_subsystem.sv
bench/rf_tb.sv

// ==== Makefile ====
# Verilator regression for the RV64I operand-read stage

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run rf_tb, check sim.log for the pass line"
	@echo "  clean  remove obj_dir and sim.log"
	@echo "  help   show this list"

test:
	rm -rf obj_dir sim.log
	verilator --binary --timing --assert -f project.f --top-module rf_tb -o rf_sim
	./obj_dir/rf_sim | tee sim.log
	@grep -q "^Simulation finished: PASS$$" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== include/rf_tb_tasks.svh ====
// Handshake and write-back tasks included inside rf_tb
// Each task starts and ends on a falling clock edge
`ifndef rf_tb_tasks_svh
`define rf_tb_tasks_svh

task automatic send_instr(input rf_pkg::instr_u w);
	pend_q.push_back(w);
	issues++;
	in_instr = w;
	in_req = 1'b1;
	@(negedge clk);
	while (!in_ack) @(negedge clk);
	in_req = 1'b0;
	@(negedge clk);
	while (in_ack) @(negedge clk);
endtask

// Write-back placed in the cycle between acceptance and operand capture
task automatic bypass_issue(input rf_pkg::instr_u w, input rf_pkg::reg_addr_t addr,
	input logic [rf_pkg::xlen-1:0] data);
	pend_q.push_back(w);
	issues++;
	in_instr = w;
	in_req = 1'b1;
	@(negedge clk);
	while (!in_ack) @(negedge clk);
	in_req = 1'b0;
	wb.we = 1'b1;
	wb.waddr = addr;
	wb.wdata = data;
	@(negedge clk);
	wb.we = 1'b0;
	while (in_ack) @(negedge clk);
endtask

task automatic write_reg(input rf_pkg::reg_addr_t addr, input logic [rf_pkg::xlen-1:0] data);
	wb.we = 1'b1;
	wb.waddr = addr;
	wb.wdata = data;
	@(negedge clk);
	wb.we = 1'b0;
endtask

task automatic drain_out(input int delay);
	while (!out_req) @(negedge clk);
	repeat (delay) @(negedge clk);
	out_ack = 1'b1;
	@(negedge clk);
	while (out_req) @(negedge clk);
	out_ack = 1'b0;
	if (pend_q.size() != 0) begin
		void'(pend_q.pop_front());
	end
	bundles++;
endtask

`endif

// ==== bench/rf_tb.sv ====
// Testbench for rf_subsystem with a 32-entry register model kept in step with write-back
// Operand bundles are expected in issue order; LFSR stimulus from a fixed seed
`timescale 1ns/1ps

module rf_tb;

	localparam int total_issues = 1024 + 16 + 9 + 2 + 8;
	localparam int cycle_limit = 40 * total_issues + 200;
	localparam logic [6:0] dec_opcodes [9] = '{rf_pkg::opc_op_imm, rf_pkg::opc_load,
		rf_pkg::opc_jalr, rf_pkg::opc_lui, rf_pkg::opc_auipc, rf_pkg::opc_jal,
		rf_pkg::opc_store, rf_pkg::opc_branch, 7'h7f};

	logic                    clk = 1'b0;
	logic                    reset;
	logic                    in_req;
	logic                    in_ack;
	rf_pkg::instr_u          in_instr;
	rf_pkg::wb_port_t        wb;
	logic                    out_req;
	logic                    out_ack;
	rf_pkg::operand_bundle_t out_bundle;
	logic [rf_pkg::xlen-1:0] ra_data;

	logic [rf_pkg::xlen-1:0] model [32];
	rf_pkg::instr_u          pend_q [$];
	rf_pkg::operand_bundle_t exp_bundle;
	logic                    exp_valid;
	logic [rf_pkg::xlen-1:0] exp_ra;
	logic [31:0]             lfsr_state = 32'h9dbe;
	int                      err_count = 0;
	int                      issues = 0;
	int                      bundles = 0;
	int                      tests = 0;

	always #4 clk = ~clk;

	rf_subsystem #(
		.BANK_REGS (8),
		.NUM_BANKS (4)
	) dut_i (
		.clk        (clk),
		.reset      (reset),
		.in_req     (in_req),
		.in_ack     (in_ack),
		.in_instr   (in_instr),
		.wb         (wb),
		.out_req    (out_req),
		.out_ack    (out_ack),
		.out_bundle (out_bundle),
		.ra_data    (ra_data)
	);

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [63:0] rand_bits(input int n);
		logic [63:0] v;
		v = '0;
		for (int k = 0; k < n; k++) begin
			lfsr_state = lfsr_step(lfsr_state);
			v = {v[62:0], lfsr_state[0]};
		end
		return v;
	endfunction

	function automatic rf_pkg::instr_u r_type(input logic [6:0] opc, input rf_pkg::reg_addr_t rd,
		input rf_pkg::reg_addr_t rs1, input rf_pkg::reg_addr_t rs2);
		rf_pkg::instr_u w;
		w.r.funct7 = 7'b0000000;
		w.r.rs2 = rs2;
		w.r.rs1 = rs1;
		w.r.funct3 = 3'b000;
		w.r.rd = rd;
		w.r.opcode = opc;
		return w;
	endfunction

	function automatic rf_pkg::instr_u i_type(input logic [6:0] opc, input rf_pkg::reg_addr_t rd,
		input rf_pkg::reg_addr_t rs1, input logic [11:0] imm);
		rf_pkg::instr_u w;
		w.i.imm12 = imm;
		w.i.rs1 = rs1;
		w.i.funct3 = 3'b000;
		w.i.rd = rd;
		w.i.opcode = opc;
		return w;
	endfunction

	// Expected operands from the opcode rules and the register model
	function automatic rf_pkg::operand_bundle_t expect_bundle(input rf_pkg::instr_u w);
		rf_pkg::operand_bundle_t b;
		logic [6:0] opc;
		logic use_imm;
		logic re2;
		logic no_rs1;
		logic known;
		opc = w.r.opcode;
		use_imm = opc inside {rf_pkg::opc_op_imm, rf_pkg::opc_load, rf_pkg::opc_jalr};
		re2 = opc inside {rf_pkg::opc_op, rf_pkg::opc_store, rf_pkg::opc_branch};
		no_rs1 = opc inside {rf_pkg::opc_lui, rf_pkg::opc_auipc, rf_pkg::opc_jal};
		known = use_imm || re2 || no_rs1;
		b.op_a = (known && !no_rs1) ? model[w.r.rs1] : '0;
		b.op_b = re2 ? model[w.r.rs2] : '0;
		if (use_imm) begin
			b.op_b = rf_pkg::xlen'($signed(w.i.imm12));
		end
		b.rd = w.r.rd;
		b.rd_we = known && !(opc inside {rf_pkg::opc_store, rf_pkg::opc_branch});
		return b;
	endfunction

	task automatic report_test(input string name, input int issue_mark, input int err_mark);
		tests++;
		$display("test %0d %s: %0d issues, %0d errors", tests, name,
			issues - issue_mark, err_count - err_mark);
	endtask

	`include "rf_tb_tasks.svh"

	// x0 is never written and model[0] stays zero
	always @(posedge clk) begin
		if (reset) begin
			for (int k = 0; k < 32; k++) begin
				model[k] <= '0;
			end
		end else if (wb.we && wb.waddr != '0) begin
			model[wb.waddr] <= wb.wdata;
		end
	end

	// Head of the issue queue against the state after the capture edge
	always @(negedge clk) begin
		exp_valid = (pend_q.size() != 0);
		if (exp_valid) begin
			exp_bundle = expect_bundle(pend_q[0]);
		end
	end

	assign exp_ra = (wb.we && wb.waddr == 5'd1) ? wb.wdata : model[1];

	a_bundle: assert property (@(posedge clk) disable iff (reset)
		$rose(out_req) |-> exp_valid && (out_bundle == exp_bundle))
		else begin
			err_count++;
			if (!exp_valid) begin
				$display("out_req rose with no instruction waiting for a bundle");
			end else begin
				$display("ERROR out_bundle got %h expected %h", out_bundle, exp_bundle);
			end
		end

	a_ra: assert property (@(posedge clk) disable iff (reset) ra_data == exp_ra)
		else begin
			err_count++;
			$display("ERROR ra_data got %h expected %h", $sampled(ra_data), $sampled(exp_ra));
		end

	a_hold: assert property (@(posedge clk) disable iff (reset)
		out_req |=> $stable(out_bundle))
		else begin
			err_count++;
			$display("out_bundle changed while out_req was high");
		end

	a_wait: assert property (@(posedge clk) disable iff (reset)
		out_req && !out_ack |=> out_req)
		else begin
			err_count++;
			$display("out_req dropped before out_ack was raised");
		end

	initial begin : watchdog
		int cycles;
		cycles = 0;
		while (cycles < cycle_limit) begin
			@(posedge clk);
			cycles++;
		end
		$display("Run stopped after %0d cycles, a handshake never completed", cycles);
		$display("Simulation finished: FAIL");
		$finish;
	end

	initial begin
		int err_mark;
		int issue_mark;
		int b_mark;
		int d1;
		int d2;
		rf_pkg::reg_addr_t sa;
		rf_pkg::instr_u w1;
		rf_pkg::instr_u w2;
		reset = 1'b1;
		in_req = 1'b0;
		in_instr = '0;
		wb = '0;
		out_ack = 1'b0;
		repeat (10) @(negedge clk);
		reset = 1'b0;

		err_mark = err_count;
		issue_mark = issues;
		for (int a = 0; a < 32; a++) begin
			for (int b = 0; b < 32; b++) begin
				send_instr(r_type(rf_pkg::opc_op, 5'(a ^ b), 5'(a), 5'(b)));
				drain_out(0);
			end
		end
		report_test("reset state", issue_mark, err_mark);

		err_mark = err_count;
		issue_mark = issues;
		for (int a = 0; a < 32; a++) begin
			write_reg(5'(a), rand_bits(64));
		end
		for (int a = 0; a < 32; a += 2) begin
			send_instr(r_type(rf_pkg::opc_op, 5'(a + 1), 5'(a), 5'(a + 1)));
			drain_out(0);
		end
		report_test("write and read-back", issue_mark, err_mark);

		// Nonzero rs1 so a cleared op_a is visible
		err_mark = err_count;
		issue_mark = issues;
		foreach (dec_opcodes[k]) begin
			w1 = i_type(dec_opcodes[k], 5'(rand_bits(5)), 5'(rand_bits(5)) | 5'd1,
				{1'(k), 11'(rand_bits(11))});
			send_instr(w1);
			drain_out(0);
		end
		report_test("decoding", issue_mark, err_mark);

		err_mark = err_count;
		issue_mark = issues;
		sa = 5'(rand_bits(5)) | 5'd2;
		bypass_issue(r_type(rf_pkg::opc_op, sa, sa, 5'(rand_bits(5))), sa, rand_bits(64));
		drain_out(0);
		bypass_issue(r_type(rf_pkg::opc_op, 5'd3, 5'd0, 5'd1), 5'd0, rand_bits(64));
		drain_out(0);
		report_test("same-cycle bypass", issue_mark, err_mark);

		err_mark = err_count;
		issue_mark = issues;
		repeat (4) begin
			write_reg(5'd1, rand_bits(64));
			write_reg(5'd0, rand_bits(64));
			write_reg(5'(rand_bits(5)), rand_bits(64));
		end
		report_test("link register", issue_mark, err_mark);

		// First ack held long enough for the second instruction to be accepted
		err_mark = err_count;
		issue_mark = issues;
		repeat (4) begin
			w1 = r_type(rf_pkg::opc_op, 5'(rand_bits(5)), 5'(rand_bits(5)), 5'(rand_bits(5)));
			w2 = i_type(rf_pkg::opc_op_imm, 5'(rand_bits(5)), 5'(rand_bits(5)),
				12'(rand_bits(12)));
			d1 = 8 + int'(rand_bits(3));
			d2 = int'(rand_bits(3));
			b_mark = bundles;
			fork
				begin
					send_instr(w1);
					send_instr(w2);
					a_overlap: assert (out_req && bundles == b_mark)
						else begin
							err_count++;
							$display("second instruction was not accepted while the first waited");
						end
				end
				begin
					drain_out(d1);
					drain_out(d2);
				end
			join
		end
		report_test("back-pressure", issue_mark, err_mark);

		repeat (4) @(negedge clk);
		a_drained: assert (pend_q.size() == 0)
			else begin
				err_count++;
				$display("%0d issued instructions never produced a bundle", pend_q.size());
			end
		$display("tests %0d, issues %0d, bundles %0d, errors %0d", tests, issues, bundles,
			err_count);
		if (err_count == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

// ==== hdl/rf_subsystem.sv ====
// Operand-read stage top with a 32 x 64-bit register file in banks
// No interlock against write-backs that land after operand capture
`timescale 1ns/1ps

module rf_subsystem #(
	parameter int BANK_REGS = 8,
	parameter int NUM_BANKS = 4
) (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     in_req,
	output logic                     in_ack,
	input  rf_pkg::instr_u           in_instr,
	input  rf_pkg::wb_port_t         wb,
	output logic                     out_req,
	input  logic                     out_ack,
	output rf_pkg::operand_bundle_t  out_bundle,
	output logic [rf_pkg::xlen-1:0]  ra_data
);

	rf_pkg::read_req_t                      rreq;
	logic                                   dec_req;
	logic                                   dec_ack;
	logic [NUM_BANKS-1:0][rf_pkg::xlen-1:0] bank_rd1;
	logic [NUM_BANKS-1:0][rf_pkg::xlen-1:0] bank_rd2;
	logic [NUM_BANKS-1:0][rf_pkg::xlen-1:0] bank_ra;

	issue_decode decode_i (
		.clk      (clk),
		.reset    (reset),
		.in_req   (in_req),
		.in_ack   (in_ack),
		.in_instr (in_instr),
		.dec_req  (dec_req),
		.dec_ack  (dec_ack),
		.rreq     (rreq)
	);

	// Every bank sees the same addresses and write port
	for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
		reg_bank #(
			.BANK_REGS (BANK_REGS),
			.BANK_ID   (b)
		) bank_i (
			.clk    (clk),
			.reset  (reset),
			.wb     (wb),
			.raddr1 (rreq.raddr1),
			.raddr2 (rreq.raddr2),
			.rd1    (bank_rd1[b]),
			.rd2    (bank_rd2[b]),
			.rd_ra  (bank_ra[b])
		);
	end

	operand_select #(
		.BANK_REGS (BANK_REGS),
		.NUM_BANKS (NUM_BANKS)
	) select_i (
		.clk        (clk),
		.reset      (reset),
		.rreq       (rreq),
		.dec_req    (dec_req),
		.dec_ack    (dec_ack),
		.bank_rd1   (bank_rd1),
		.bank_rd2   (bank_rd2),
		.bank_ra    (bank_ra),
		.wb         (wb),
		.out_req    (out_req),
		.out_ack    (out_ack),
		.out_bundle (out_bundle),
		.ra_data    (ra_data)
	);

	// Banks must cover exactly the 5-bit register space
	a_bank_geometry: assert property (@(posedge clk)
		NUM_BANKS * BANK_REGS == 2 ** rf_pkg::addr_w)
		else $error("bank geometry %0d x %0d does not give 32 registers",
			NUM_BANKS, BANK_REGS);

endmodule

// ==== hdl/operand_select.sv ====
// Picks bank data, applies same-cycle write bypass and read-enable gating
// Captures one bundle at a time; a new request waits until the output is idle
`timescale 1ns/1ps

module operand_select #(
	parameter int BANK_REGS = 8,
	parameter int NUM_BANKS = 4
) (
	input  logic                                     clk,
	input  logic                                     reset,
	input  rf_pkg::read_req_t                        rreq,
	input  logic                                     dec_req,
	output logic                                     dec_ack,
	input  logic [NUM_BANKS-1:0][rf_pkg::xlen-1:0]   bank_rd1,
	input  logic [NUM_BANKS-1:0][rf_pkg::xlen-1:0]   bank_rd2,
	input  logic [NUM_BANKS-1:0][rf_pkg::xlen-1:0]   bank_ra,
	input  rf_pkg::wb_port_t                         wb,
	output logic                                     out_req,
	input  logic                                     out_ack,
	output rf_pkg::operand_bundle_t                  out_bundle,
	output logic [rf_pkg::xlen-1:0]                  ra_data
);

	localparam int idx_w = $clog2(BANK_REGS);

	logic                    capture;
	logic [rf_pkg::xlen-1:0] rs1_val;
	logic [rf_pkg::xlen-1:0] rs2_val;
	rf_pkg::operand_bundle_t next_bundle;

	// Bank select, then bypass, then enable gating
	function automatic logic [rf_pkg::xlen-1:0] read_port(
		input logic                                   re,
		input rf_pkg::reg_addr_t                      addr,
		input logic [NUM_BANKS-1:0][rf_pkg::xlen-1:0] data,
		input rf_pkg::wb_port_t                       w
	);
		logic [rf_pkg::xlen-1:0] val;
		val = data[addr[rf_pkg::addr_w-1:idx_w]];
		if (w.we && (w.waddr == addr) && (addr != '0)) begin
			val = w.wdata;
		end
		if (!re) begin
			val = '0;
		end
		return val;
	endfunction

	assign rs1_val = read_port(rreq.re1, rreq.raddr1, bank_rd1, wb);
	assign rs2_val = read_port(rreq.re2, rreq.raddr2, bank_rd2, wb);

	always_comb begin
		next_bundle.op_a = rs1_val;
		next_bundle.op_b = rreq.use_imm ? rreq.imm : rs2_val;
		next_bundle.rd = rreq.rd;
		next_bundle.rd_we = rreq.rd_we;
	end

	// x1 is always read and routed through bank 0 by its address
	assign ra_data = read_port(1'b1, rf_pkg::addr_w'(1), bank_ra, wb);

	// Fresh request and output channel fully at rest
	assign capture = dec_req && !dec_ack && !out_req && !out_ack;

	always_ff @(posedge clk) begin
		if (reset) begin
			dec_ack <= 1'b0;
			out_req <= 1'b0;
		end else begin
			if (capture) begin
				dec_ack <= 1'b1;
			end else if (!dec_req) begin
				dec_ack <= 1'b0;
			end
			if (capture) begin
				out_req <= 1'b1;
			end else if (out_ack) begin
				out_req <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (capture) begin
			out_bundle <= next_bundle;
		end
	end

	// Downstream may sample the bundle at any point of a slow handshake
	a_bundle_stable: assert property (@(posedge clk) disable iff (reset)
		out_req |=> $stable(out_bundle))
		else $error("out_bundle changed while out_req was high");

endmodule

// ==== hdl/reg_bank.sv ====
// One bank of BANK_REGS registers picked by the upper address bits
// BANK_REGS must be a power of two and at least 2; bank 0 holds x0 and x1
`timescale 1ns/1ps

module reg_bank #(
	parameter int BANK_REGS = 8,
	parameter int BANK_ID = 0
) (
	input  logic                     clk,
	input  logic                     reset,
	input  rf_pkg::wb_port_t         wb,
	input  rf_pkg::reg_addr_t        raddr1,
	input  rf_pkg::reg_addr_t        raddr2,
	output logic [rf_pkg::xlen-1:0]  rd1,
	output logic [rf_pkg::xlen-1:0]  rd2,
	output logic [rf_pkg::xlen-1:0]  rd_ra
);

	localparam int idx_w = $clog2(BANK_REGS);
	localparam int hi_w = rf_pkg::addr_w - idx_w;
	localparam logic [hi_w-1:0] bank_sel = hi_w'(BANK_ID);

	logic [rf_pkg::xlen-1:0] regs [BANK_REGS];
	logic [idx_w-1:0]        widx;
	logic                    write_en;

	assign widx = wb.waddr[idx_w-1:0];

	// Bank 0 entry 0 is x0 and is never written
	assign write_en = wb.we && (wb.waddr[rf_pkg::addr_w-1:idx_w] == bank_sel)
		&& !((BANK_ID == 0) && (widx == '0));

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < BANK_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (write_en) begin
			regs[widx] <= wb.wdata;
		end
	end

	// Raw storage reads with the bypass applied in the selector
	assign rd1 = regs[raddr1[idx_w-1:0]];
	assign rd2 = regs[raddr2[idx_w-1:0]];

	// Local entry 1 is x1 only in bank 0
	assign rd_ra = regs[1];

	if (BANK_ID == 0) begin : g_x0_check
		a_x0_zero: assert property (@(posedge clk) disable iff (reset) regs[0] == '0)
			else $error("x0 storage holds %h", regs[0]);
	end

endmodule

// ==== hdl/issue_decode.sv ====
// Accepts one instruction per four-phase handshake and decodes it
// Holds the decoded request until the selector has closed its handshake
`timescale 1ns/1ps

module issue_decode (
	input  logic               clk,
	input  logic               reset,
	input  logic               in_req,
	output logic               in_ack,
	input  rf_pkg::instr_u     in_instr,
	output logic               dec_req,
	input  logic               dec_ack,
	output rf_pkg::read_req_t  rreq
);

	typedef enum logic [1:0] {
		st_idle,
		st_req,
		st_release
	} dec_state_e;

	dec_state_e        state;
	logic              accept;
	rf_pkg::read_req_t dec;

	// New request only when both handshakes are back at rest
	assign accept = in_req && !in_ack && (state == st_idle);
	assign dec_req = (state == st_req);

	always_comb begin
		dec = '0;
		dec.raddr1 = in_instr.r.rs1;
		dec.raddr2 = in_instr.r.rs2;
		dec.rd = in_instr.r.rd;
		dec.imm = {{(rf_pkg::xlen - 12){in_instr.i.imm12[11]}}, in_instr.i.imm12};
		case (in_instr.r.opcode)
			rf_pkg::opc_op: begin
				dec.re1 = 1'b1;
				dec.re2 = 1'b1;
				dec.rd_we = 1'b1;
			end
			rf_pkg::opc_op_imm, rf_pkg::opc_load, rf_pkg::opc_jalr: begin
				dec.re1 = 1'b1;
				dec.use_imm = 1'b1;
				dec.rd_we = 1'b1;
			end
			rf_pkg::opc_store, rf_pkg::opc_branch: begin
				dec.re1 = 1'b1;
				dec.re2 = 1'b1;
			end
			// Upper-immediate and jump forms write rd but read nothing
			rf_pkg::opc_lui, rf_pkg::opc_auipc, rf_pkg::opc_jal: begin
				dec.rd_we = 1'b1;
			end
			default: begin
				dec.re1 = 1'b0;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			in_ack <= 1'b0;
			state <= st_idle;
		end else begin
			if (accept) begin
				in_ack <= 1'b1;
			end else if (!in_req) begin
				in_ack <= 1'b0;
			end
			case (state)
				st_idle: if (accept) state <= st_req;
				st_req: if (dec_ack) state <= st_release;
				st_release: if (!dec_ack) state <= st_idle;
				default: state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			rreq <= dec;
		end
	end

	// The selector may sample the request on any edge while dec_req is up
	a_rreq_stable: assert property (@(posedge clk) disable iff (reset)
		dec_req |=> $stable(rreq))
		else $error("rreq changed while dec_req was high");

endmodule

// ==== hdl/rf_pkg.sv ====
// Shared types for the RV64I operand-read stage
// Only the I-type immediate format is decoded
package rf_pkg;

	localparam int xlen = 64;
	localparam int addr_w = 5;

	typedef logic [addr_w-1:0] reg_addr_t;

	// Base opcodes only, no compressed forms
	localparam logic [6:0] opc_op     = 7'b0110011;
	localparam logic [6:0] opc_op_imm = 7'b0010011;
	localparam logic [6:0] opc_load   = 7'b0000011;
	localparam logic [6:0] opc_store  = 7'b0100011;
	localparam logic [6:0] opc_branch = 7'b1100011;
	localparam logic [6:0] opc_jalr   = 7'b1100111;
	localparam logic [6:0] opc_lui    = 7'b0110111;
	localparam logic [6:0] opc_auipc  = 7'b0010111;
	localparam logic [6:0] opc_jal    = 7'b1101111;

	typedef struct packed {
		logic [6:0] funct7;
		reg_addr_t  rs2;
		reg_addr_t  rs1;
		logic [2:0] funct3;
		reg_addr_t  rd;
		logic [6:0] opcode;
	} instr_r_t;

	typedef struct packed {
		logic [11:0] imm12;
		reg_addr_t   rs1;
		logic [2:0]  funct3;
		reg_addr_t   rd;
		logic [6:0]  opcode;
	} instr_i_t;

	// One instruction word seen as R-type or I-type
	typedef union packed {
		instr_r_t r;
		instr_i_t i;
	} instr_u;

	typedef struct packed {
		reg_addr_t        raddr1;
		logic             re1;
		reg_addr_t        raddr2;
		logic             re2;
		logic             use_imm;
		logic [xlen-1:0]  imm;
		reg_addr_t        rd;
		logic             rd_we;
	} read_req_t;

	typedef struct packed {
		logic            we;
		reg_addr_t       waddr;
		logic [xlen-1:0] wdata;
	} wb_port_t;

	typedef struct packed {
		logic [xlen-1:0] op_a;
		logic [xlen-1:0] op_b;
		reg_addr_t       rd;
		logic            rd_we;
	} operand_bundle_t;

endpackage
